/* compile.f */
+incdir+verification
hdl/hwloop_pkg.sv
hdl/hwloop_regs.sv
hdl/hwloop_controller.sv
hdl/hwloop_pc_sequencer.sv
hdl/hwloop_unit_top.sv
verification/hwloop_unit_tb.sv

/* Bender.yml */
package:
  name: hwloop_unit

sources:
  # design, package first
  - files:
      - hdl/hwloop_pkg.sv
      - hdl/hwloop_regs.sv
      - hdl/hwloop_controller.sv
      - hdl/hwloop_pc_sequencer.sv
      - hdl/hwloop_unit_top.sv

  # testbench, the table header lives next to it
  - target: test
    include_dirs:
      - verification
    files:
      - verification/hwloop_unit_tb.sv

/* verification/hwloop_tb_table.svh */
// hardware loop testbench table
// one row per scenario, all six loop registers are rewritten before each row

`ifndef HWLOOP_TB_TABLE_SVH
`define HWLOOP_TB_TABLE_SVH

// each row holds set 0 start, end and count, then set 1 start, end and count,
// then entry pc, exit pc, stall enable, expected retirements and expected jumps
typedef struct packed {
  hwlp_addr_t  s0_start;
  hwlp_addr_t  s0_end;
  hwlp_addr_t  s0_cnt;
  hwlp_addr_t  s1_start;
  hwlp_addr_t  s1_end;
  hwlp_addr_t  s1_cnt;
  hwlp_addr_t  entry_pc;
  hwlp_addr_t  exit_pc;
  logic [31:0] stall_en;
  logic [31:0] exp_ret;
  logic [31:0] exp_jmp;
} loop_row_t;

localparam int num_rows = 7;

localparam loop_row_t loop_table [num_rows] = '{
  // single loop, body of 4, three passes
  '{'h100, 'h110, 3, 'h000, 'h000, 0, 'h100, 'h110, 0, 12, 2},
  // count 1 runs the body once
  '{'h200, 'h20c, 1, 'h000, 'h000, 0, 'h200, 'h20c, 0, 3, 0},
  // count 0 behaves like count 1
  '{'h300, 'h308, 0, 'h000, 'h000, 0, 'h300, 'h308, 0, 2, 0},
  // nested, inner count stays at 1 on the second outer pass
  '{'h404, 'h40c, 3, 'h400, 'h414, 2, 'h400, 'h414, 0, 14, 3},
  // nested with a shared end, set 0 wins while it is live
  '{'h508, 'h510, 2, 'h500, 'h510, 3, 'h500, 'h510, 0, 14, 3},
  // rows 0 and 4 again under random stalls
  '{'h100, 'h110, 3, 'h000, 'h000, 0, 'h100, 'h110, 1, 12, 2},
  '{'h508, 'h510, 2, 'h500, 'h510, 3, 'h500, 'h510, 1, 14, 3}
};

`endif

/* verification/hwloop_unit_tb.sv */
// hardware loop unit testbench
// runs the loop table through the unit and tracks pc and counts with a small model

`timescale 1ns/1ps

module hwloop_unit_tb;

  import hwloop_pkg::*;

  localparam int clk_period = 40;

  `include "hwloop_tb_table.svh"

  logic                  clk;
  logic                  rst_n;
  logic                  cfg_we_i;
  logic [hwlp_idx_w-1:0] cfg_idx_i;
  hwlp_field_e           cfg_field_i;
  hwlp_addr_t            cfg_wdata_i;
  logic                  id_valid_i;
  logic                  instr_valid_i;
  logic                  pc_set_i;
  hwlp_addr_t            pc_set_addr_i;
  hwlp_addr_t            pc_o;
  logic                  jump_o;
  hwlp_addr_t            target_o;
  logic                  jump_pc_o;
  hwlp_addr_t            target_pc_o;

  integer seed;
  int     cycle_cnt;
  int     cycle_limit;

  hwloop_unit_top hwloop_unit_top_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_we_i      (cfg_we_i),
    .cfg_idx_i     (cfg_idx_i),
    .cfg_field_i   (cfg_field_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .id_valid_i    (id_valid_i),
    .instr_valid_i (instr_valid_i),
    .pc_set_i      (pc_set_i),
    .pc_set_addr_i (pc_set_addr_i),
    .pc_o          (pc_o),
    .jump_o        (jump_o),
    .target_o      (target_o),
    .jump_pc_o     (jump_pc_o),
    .target_pc_o   (target_pc_o)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // watchdog with a limit worked out from the table
  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge clk);
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
        $display("the run hung, no loop exit reached after %0d cycles", cycle_cnt);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
      end
    end
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // one write per falling edge and the caller drops the strobe
  task automatic write_reg(input int idx, input hwlp_field_e field, input hwlp_addr_t data);
    @(negedge clk);
    cfg_we_i    = 1'b1;
    cfg_idx_i   = idx[hwlp_idx_w-1:0];
    cfg_field_i = field;
    cfg_wdata_i = data;
  endtask

  task automatic run_row(input loop_row_t row);
    hwlp_addr_t starts [hwlp_n_regs];
    hwlp_addr_t ends [hwlp_n_regs];
    hwlp_addr_t model_cnt [hwlp_n_regs];
    hwlp_addr_t model_pc;
    hwlp_addr_t exp_target;
    hwlp_addr_t last_target;
    logic       exp_jump;
    logic       last_jump;
    logic       retire;
    int         win;
    int         k;
    int         retired;
    int         jumps;
    integer     r;

    starts[0]    = row.s0_start;
    ends[0]      = row.s0_end;
    model_cnt[0] = row.s0_cnt;
    starts[1]    = row.s1_start;
    ends[1]      = row.s1_end;
    model_cnt[1] = row.s1_cnt;
    write_reg(0, HWLP_FIELD_START, row.s0_start);
    write_reg(0, HWLP_FIELD_END, row.s0_end);
    write_reg(0, HWLP_FIELD_COUNT, row.s0_cnt);
    write_reg(1, HWLP_FIELD_START, row.s1_start);
    write_reg(1, HWLP_FIELD_END, row.s1_end);
    write_reg(1, HWLP_FIELD_COUNT, row.s1_cnt);
    @(negedge clk);
    cfg_we_i      = 1'b0;
    pc_set_i      = 1'b1;
    pc_set_addr_i = row.entry_pc;
    @(negedge clk);
    pc_set_i    = 1'b0;
    model_pc    = row.entry_pc;
    retired     = 0;
    jumps       = 0;
    last_jump   = 1'b0;
    last_target = '0;
    check_value("pc_o at entry", pc_o, model_pc);
    while (pc_o != row.exit_pc) begin
      id_valid_i    = 1'b1;
      instr_valid_i = 1'b1;
      if (row.stall_en != 0) begin
        r = $random(seed);
        case (r[2:0])
          3'd0: id_valid_i = 1'b0;
          3'd1: instr_valid_i = 1'b0;
          3'd2: begin
            id_valid_i    = 1'b0;
            instr_valid_i = 1'b0;
          end
          default: ;
        endcase
      end
      retire = id_valid_i && instr_valid_i;
      // combinational outputs settle well before the rising edge
      #(clk_period / 4);
      exp_jump   = 1'b0;
      exp_target = '0;
      win        = 0;
      // lowest live set whose end follows the current pc
      for (k = 0; k < hwlp_n_regs && !exp_jump; k++) begin
        if (retire && ((model_pc + hwlp_instr_bytes) == ends[k]) && (model_cnt[k] >= 2)) begin
          exp_jump   = 1'b1;
          exp_target = starts[k];
          win        = k;
        end
      end
      check_value("jump_o", jump_o, exp_jump);
      if (exp_jump) begin
        check_value("target_o", target_o, exp_target);
      end
      if (retire) begin
        retired++;
        if (jump_o) begin
          jumps++;
        end
        if (exp_jump) begin
          model_cnt[win] = model_cnt[win] - 1;
          model_pc       = exp_target;
        end else begin
          model_pc = model_pc + hwlp_instr_bytes;
        end
      end
      // registered flag follows every valid instruction and holds otherwise
      if (instr_valid_i) begin
        last_jump   = exp_jump;
        last_target = exp_target;
      end
      @(negedge clk);
      // pc holds on stalls and tracks the model every cycle
      check_value("pc_o", pc_o, model_pc);
      check_value("jump_pc_o", jump_pc_o, last_jump);
      if (last_jump) begin
        check_value("target_pc_o", target_pc_o, last_target);
      end
    end
    id_valid_i    = 1'b0;
    instr_valid_i = 1'b0;
    check_value("retirements", retired, row.exp_ret);
    check_value("jumps", jumps, row.exp_jmp);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int total_ret;
    int row_idx;

    seed          = 35;
    rst_n         = 1'b0;
    cfg_we_i      = 1'b0;
    cfg_idx_i     = '0;
    cfg_field_i   = HWLP_FIELD_START;
    cfg_wdata_i   = '0;
    id_valid_i    = 1'b0;
    instr_valid_i = 1'b0;
    pc_set_i      = 1'b0;
    pc_set_addr_i = '0;
    total_ret     = 0;
    foreach (loop_table[i]) begin
      total_ret += loop_table[i].exp_ret;
    end
    // four cycles per retirement for stalls, ten per row for setup, reset and a margin
    cycle_limit = 4 * total_ret + 16 + 10 * num_rows + 100;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("pc_o after reset", pc_o, 0);
    check_value("jump_o after reset", jump_o, 0);
    check_value("jump_pc_o after reset", jump_pc_o, 0);
    check_value("target_pc_o after reset", target_pc_o, 0);
    for (row_idx = 0; row_idx < num_rows; row_idx++) begin
      run_row(loop_table[row_idx]);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

/* hdl/hwloop_unit_top.sv */
// hardware loop unit top
// register file, loop controller and pc sequencer wired together

`timescale 1ns/1ps

module hwloop_unit_top (
  input  logic                              clk,
  input  logic                              rst_n,

  // software write port for the loop registers
  input  logic                              cfg_we_i,
  input  logic [hwloop_pkg::hwlp_idx_w-1:0] cfg_idx_i,
  input  hwloop_pkg::hwlp_field_e           cfg_field_i,
  input  hwloop_pkg::hwlp_addr_t            cfg_wdata_i,

  // instruction stream qualifiers
  input  logic                              id_valid_i,
  input  logic                              instr_valid_i,

  // pc reload
  input  logic                              pc_set_i,
  input  hwloop_pkg::hwlp_addr_t            pc_set_addr_i,

  output hwloop_pkg::hwlp_addr_t            pc_o,

  // combinational loop redirect
  output logic                              jump_o,
  output hwloop_pkg::hwlp_addr_t            target_o,

  // registered redirect for fetch
  output logic                              jump_pc_o,
  output hwloop_pkg::hwlp_addr_t            target_pc_o
);

  import hwloop_pkg::*;

  // register file to controller
  hwlp_addr_t [hwlp_n_regs-1:0] start_addr;
  hwlp_addr_t [hwlp_n_regs-1:0] end_addr;
  hwlp_addr_t [hwlp_n_regs-1:0] counter;
  // controller back to register file
  logic       [hwlp_n_regs-1:0] dec_cnt;

  //////////////////////////////////////////////////
  // loop registers
  //////////////////////////////////////////////////

  hwloop_regs hwloop_regs_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_we_i     (cfg_we_i),
    .cfg_idx_i    (cfg_idx_i),
    .cfg_field_i  (cfg_field_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .dec_cnt_i    (dec_cnt),
    .start_addr_o (start_addr),
    .end_addr_o   (end_addr),
    .counter_o    (counter)
  );

  //////////////////////////////////////////////////
  // loop controller
  //////////////////////////////////////////////////

  hwloop_controller hwloop_controller_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .id_valid_i    (id_valid_i),
    .instr_valid_i (instr_valid_i),
    .current_pc_i  (pc_o),
    .start_addr_i  (start_addr),
    .end_addr_i    (end_addr),
    .counter_i     (counter),
    .dec_cnt_o     (dec_cnt),
    .jump_o        (jump_o),
    .target_o      (target_o),
    .jump_q_o      (jump_pc_o),
    .target_q_o    (target_pc_o)
  );

  //////////////////////////////////////////////////
  // pc sequencer
  //////////////////////////////////////////////////

  // the same cycle jump feeds the pc so a redirect costs no bubble
  hwloop_pc_sequencer hwloop_pc_sequencer_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .id_valid_i    (id_valid_i),
    .instr_valid_i (instr_valid_i),
    .pc_set_i      (pc_set_i),
    .pc_set_addr_i (pc_set_addr_i),
    .loop_jump_i   (jump_o),
    .loop_target_i (target_o),
    .pc_o          (pc_o)
  );

endmodule

/* hdl/hwloop_pc_sequencer.sv */
// instruction address sequencer
// holds the pc, takes reloads, loop jumps or the sequential step

`timescale 1ns/1ps

module hwloop_pc_sequencer (
  input  logic                   clk,
  input  logic                   rst_n,

  // retire qualifiers
  input  logic                   id_valid_i,
  input  logic                   instr_valid_i,

  // software pc reload with priority over everything else
  input  logic                   pc_set_i,
  input  hwloop_pkg::hwlp_addr_t pc_set_addr_i,

  // redirect from the loop controller
  input  logic                   loop_jump_i,
  input  hwloop_pkg::hwlp_addr_t loop_target_i,

  output hwloop_pkg::hwlp_addr_t pc_o
);

  import hwloop_pkg::*;

  logic       retire;
  hwlp_addr_t pc_next;

  //////////////////////////////////////////////////
  // next pc
  //////////////////////////////////////////////////

  // instruction leaves decode only with both levels high
  assign retire = id_valid_i && instr_valid_i;

  // loop end redirect or one sequential instruction step
  always_comb begin
    if (loop_jump_i) begin
      pc_next = loop_target_i;
    end else begin
      pc_next = pc_o + hwlp_addr_t'(hwlp_instr_bytes);
    end
  end

  //////////////////////////////////////////////////
  // pc register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_o <= '0;
    end else if (pc_set_i) begin
      pc_o <= pc_set_addr_i;
    end else if (retire) begin
      pc_o <= pc_next;
    end
    // pc holds during a stall
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // an aligned pc stays aligned through steps, holds and aligned redirects
  pc_align_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    (pc_set_i ? ((pc_set_addr_i % hwlp_instr_bytes) == 0)
              : (((pc_o % hwlp_instr_bytes) == 0) &&
                 (!loop_jump_i || ((loop_target_i % hwlp_instr_bytes) == 0))))
      |=> ((pc_o % hwlp_instr_bytes) == 0)
  );

endmodule

/* hdl/hwloop_controller.sv */
// hardware loop controller
// matches the next pc against loop end addresses, picks the jump target
// and raises the count decrement for the winning set

`timescale 1ns/1ps

module hwloop_controller (
  input  logic                                                  clk,
  input  logic                                                  rst_n,

  // retire qualifiers and current pc
  input  logic                                                  id_valid_i,
  input  logic                                                  instr_valid_i,
  input  hwloop_pkg::hwlp_addr_t                                current_pc_i,

  // loop register contents
  input  hwloop_pkg::hwlp_addr_t [hwloop_pkg::hwlp_n_regs-1:0]  start_addr_i,
  input  hwloop_pkg::hwlp_addr_t [hwloop_pkg::hwlp_n_regs-1:0]  end_addr_i,
  input  hwloop_pkg::hwlp_addr_t [hwloop_pkg::hwlp_n_regs-1:0]  counter_i,

  // decrement strobes back to the register file
  output logic [hwloop_pkg::hwlp_n_regs-1:0]                    dec_cnt_o,

  // combinational jump in the same cycle as the matching pc
  output logic                                                  jump_o,
  output hwloop_pkg::hwlp_addr_t                                target_o,

  // registered copy for the fetch side
  output logic                                                  jump_q_o,
  output hwloop_pkg::hwlp_addr_t                                target_q_o
);

  import hwloop_pkg::*;

  hwlp_addr_t             next_pc;
  logic                   retire;
  logic [hwlp_n_regs-1:0] end_hit;
  logic [hwlp_n_regs-1:0] cnt_live;
  logic [hwlp_n_regs-1:0] match;

  //////////////////////////////////////////////////
  // per-set match
  //////////////////////////////////////////////////

  // address of the instruction after the current one
  assign next_pc = current_pc_i + hwlp_addr_t'(hwlp_instr_bytes);
  assign retire  = id_valid_i && instr_valid_i;

  always_comb begin
    for (int k = 0; k < hwlp_n_regs; k++) begin
      end_hit[k]  = (next_pc == end_addr_i[k]);
      // count 1 means the last pass falls through
      cnt_live[k] = (counter_i[k] >= hwlp_addr_t'(2));
      match[k]    = end_hit[k] && cnt_live[k] && retire;
    end
  end

  //////////////////////////////////////////////////
  // priority select
  //////////////////////////////////////////////////

  // walk from the top down so the lowest matching index is left standing
  always_comb begin
    target_o  = '0;
    dec_cnt_o = '0;
    for (int k = hwlp_n_regs - 1; k >= 0; k--) begin
      if (match[k]) begin
        target_o  = start_addr_i[k];
        dec_cnt_o = '0;
        dec_cnt_o[k] = 1'b1;
      end
    end
  end

  assign jump_o = |match;

  //////////////////////////////////////////////////
  // registered copy for fetch
  //////////////////////////////////////////////////

  // follows every valid instruction and holds while nothing is valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      jump_q_o   <= 1'b0;
      target_q_o <= '0;
    end else if (instr_valid_i) begin
      jump_q_o   <= jump_o;
      target_q_o <= target_o;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // a jump takes one iteration from the lowest matching set
  jump_dec_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    jump_o |-> ($onehot(dec_cnt_o) && ((dec_cnt_o & match) == dec_cnt_o)
                && ((match & (dec_cnt_o - 1'b1)) == '0))
  );

  // no redirect and no count change without a retiring instruction
  jump_retire_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(id_valid_i && instr_valid_i) |-> (!jump_o && (dec_cnt_o == '0))
  );

endmodule

/* hdl/hwloop_regs.sv */
// hardware loop register file
// start, end and count per loop set, software write port and count decrement

`timescale 1ns/1ps

module hwloop_regs (
  input  logic                                                  clk,
  input  logic                                                  rst_n,

  // software write port
  input  logic                                                  cfg_we_i,
  input  logic [hwloop_pkg::hwlp_idx_w-1:0]                     cfg_idx_i,
  input  hwloop_pkg::hwlp_field_e                               cfg_field_i,
  input  hwloop_pkg::hwlp_addr_t                                cfg_wdata_i,

  // decrement strobes from the controller
  input  logic [hwloop_pkg::hwlp_n_regs-1:0]                    dec_cnt_i,

  // register contents, straight from the flops
  output hwloop_pkg::hwlp_addr_t [hwloop_pkg::hwlp_n_regs-1:0]  start_addr_o,
  output hwloop_pkg::hwlp_addr_t [hwloop_pkg::hwlp_n_regs-1:0]  end_addr_o,
  output hwloop_pkg::hwlp_addr_t [hwloop_pkg::hwlp_n_regs-1:0]  counter_o
);

  import hwloop_pkg::*;

  // one write enable per set
  logic [hwlp_n_regs-1:0] set_we;

  //////////////////////////////////////////////////
  // write decode
  //////////////////////////////////////////////////

  always_comb begin
    for (int k = 0; k < hwlp_n_regs; k++) begin
      set_we[k] = cfg_we_i && (cfg_idx_i == hwlp_idx_w'(k));
    end
  end

  //////////////////////////////////////////////////
  // address registers
  //////////////////////////////////////////////////

  // start and end only move on software writes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_addr_o <= '0;
      end_addr_o   <= '0;
    end else begin
      for (int k = 0; k < hwlp_n_regs; k++) begin
        if (set_we[k] && (cfg_field_i == HWLP_FIELD_START)) begin
          start_addr_o[k] <= cfg_wdata_i;
        end
        if (set_we[k] && (cfg_field_i == HWLP_FIELD_END)) begin
          end_addr_o[k] <= cfg_wdata_i;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // iteration counters
  //////////////////////////////////////////////////

  // a software write beats a decrement in the same cycle
  // the controller only strobes counts of 2 or more, so no wrap below zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      counter_o <= '0;
    end else begin
      for (int k = 0; k < hwlp_n_regs; k++) begin
        if (set_we[k] && (cfg_field_i == HWLP_FIELD_COUNT)) begin
          counter_o[k] <= cfg_wdata_i;
        end else if (dec_cnt_i[k]) begin
          counter_o[k] <= counter_o[k] - hwlp_addr_t'(1);
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // the controller picks a single loop per retired instruction
  dec_onehot_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(dec_cnt_i)
  );

endmodule

/* hdl/hwloop_pkg.sv */
// hardware loop package
// shared sizes, the address type and the loop register field select

package hwloop_pkg;

  //////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////

  // number of loop register sets, set 0 is the innermost loop
  localparam int unsigned hwlp_n_regs = 2;

  // index width for selecting a set on the write port
  // kept at one bit minimum so a single set still has a legal index port
  localparam int unsigned hwlp_idx_w = (hwlp_n_regs > 1) ? $clog2(hwlp_n_regs) : 1;

  // address and count width
  localparam int unsigned hwlp_addr_w = 32;

  // fixed instruction size, no compressed instructions here
  localparam int unsigned hwlp_instr_bytes = 4;

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  // used for pc, start, end and iteration count alike
  typedef logic [hwlp_addr_w-1:0] hwlp_addr_t;

  // selects which register of a set is written
  typedef enum logic [1:0] {
    HWLP_FIELD_START = 2'd0,
    HWLP_FIELD_END   = 2'd1,
    HWLP_FIELD_COUNT = 2'd2
  } hwlp_field_e;

  // encoding 2'd3 is unused
  // writes carrying it are ignored by the register file

endpackage
